// File: all.f
+incdir+verilog
verilog/boardPkg.sv
verilog/busDecoder.sv
verilog/clockStepper.sv
verilog/stopwatch.sv
verilog/lfsrRandom.sv
verilog/breakUnit.sv
verilog/hexDisplay.sv
verilog/boardTop.sv
bench/board_assert.sv
bench/boardTb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the board testbench with Verilator, runs it and scans the log
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module boardTb \
    -Mdir obj_dir -f all.f \
    && ./obj_dir/VboardTb +verilator+error+limit+1000 2>&1 | tee sim.log \
    || { echo "build or simulation did not complete"; exit 1; }

grep -q "Regression failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

// File: bench/boardTb.sv
// board testbench
// drives the bus, keys and cpu inputs through every checked behavior
`timescale 1ns/1ns
`include "board_consts.svh"

module boardTb;
    import boardPkg::*;

    // ~650 cycles of stimulus, limit keeps a wide margin
    localparam int CycleLimit = 3000;

    logic       iCLK;
    logic       rstN;
    logic [9:0] SW;
    logic [3:0] KEY;
    wordT       pc;
    wordT       instr;
    logic       ebreak;
    logic       readEnable;
    logic       writeEnable;
    wordT       address;
    wordT       writeData;
    logic [3:0] byteEnable;
    wordT       readData;
    logic       cpuTick;
    segT        HEX0;
    segT        HEX1;
    segT        HEX2;
    segT        HEX3;
    segT        HEX4;
    segT        HEX5;
    logic [9:0] LEDR;

    integer seed;
    int     tbErrors;
    int     cycleCount;

    boardTop boardTop_inst (.*);

    initial begin
        iCLK = 1'b0;
        forever #50 iCLK = ~iCLK;
    end

    // one-cycle write strobe
    task automatic busWrite(input wordT addr, input wordT data, input logic [3:0] be);
        @(posedge iCLK);
        writeEnable <= 1'b1;
        address     <= addr;
        writeData   <= data;
        byteEnable  <= be;
        @(posedge iCLK);
        writeEnable <= 1'b0;
    endtask

    // read data is sampled mid-cycle, away from the edges
    task automatic busRead(input wordT addr, output wordT data);
        @(posedge iCLK);
        readEnable <= 1'b1;
        address    <= addr;
        @(negedge iCLK);
        data = readData;
        @(posedge iCLK);
        readEnable <= 1'b0;
    endtask

    task automatic readExpect(input wordT addr, input wordT expected, input string what);
        wordT got;
        busRead(addr, got);
        if (got !== expected) begin
            $display("FAILED at %0t: %s read %h, expected %h", $time, what, got, expected);
            tbErrors++;
        end
    endtask

    // active-low key held for two cycles
    task automatic pressKey(input int idx);
        @(posedge iCLK);
        KEY[idx] <= 1'b0;
        repeat (2) @(posedge iCLK);
        KEY[idx] <= 1'b1;
    endtask

    task automatic waitTick(input int limit);
        int waited;
        waited = 0;
        @(negedge iCLK);
        while (!cpuTick && waited < limit) begin
            @(negedge iCLK);
            waited++;
        end
        if (!cpuTick) begin
            $display("no cpu tick arrived within %0d cycles at %0t", limit, $time);
            tbErrors++;
        end
    endtask

    task automatic waitHalt(input logic level, input int limit);
        int waited;
        waited = 0;
        @(negedge iCLK);
        while (LEDR[1] !== level && waited < limit) begin
            @(negedge iCLK);
            waited++;
        end
        if (LEDR[1] !== level) begin
            $display("halt lamp did not reach %0b within %0d cycles at %0t", level, limit,
                     $time);
            tbErrors++;
        end
    endtask

    // run limit
    initial begin
        cycleCount = 0;
        while (cycleCount < CycleLimit) begin
            @(posedge iCLK);
            cycleCount++;
        end
        $display("run stopped after %0d cycles without finishing", CycleLimit);
        $display("Regression failed");
        $finish;
    end

    initial begin
        wordT value;
        wordT bp;
        wordT junk;
        int   fails;
        seed        = 32'h233e;
        tbErrors    = 0;
        rstN        = 1'b0;
        SW          = '0;
        KEY         = 4'hF;
        pc          = '0;
        instr       = '0;
        ebreak      = 1'b0;
        readEnable  = 1'b0;
        writeEnable = 1'b0;
        address     = '0;
        writeData   = '0;
        byteEnable  = '0;
        repeat (16) @(posedge iCLK);
        rstN <= 1'b1;

        // display, all four select codes twice
        for (int i = 0; i < 8; i++) begin
            @(posedge iCLK);
            pc      <= $random(seed);
            instr   <= $random(seed);
            SW[9:8] <= i[1:0];
            repeat (2) @(posedge iCLK);
        end

        // divider switches and unmapped reads
        for (int i = 0; i < 6; i++) begin
            @(posedge iCLK);
            SW[4:0] <= 5'($random(seed));
            @(posedge iCLK);
            readExpect(`DIVIDER_ADDRESS, {27'b0, SW[4:0]}, "divider");
        end
        for (int i = 0; i < 4; i++) begin
            value = 32'h0000_1000 | (32'($random(seed)) & 32'h0000_0FFC);
            readExpect(value, 32'h0, "unmapped address");
        end

        // stopwatch reads at uneven distances from the clear
        busWrite(`STOPWATCH_ADDRESS, $random(seed), 4'hF);
        for (int i = 0; i < 6; i++) begin
            repeat ((32'($random(seed)) & 15) + 1) @(posedge iCLK);
            busRead(`STOPWATCH_ADDRESS, junk);
        end

        // lfsr: reset value, seeding, stepping, zero write ignored
        readExpect(`LFSR_ADDRESS, `LFSR_SEED, "lfsr after reset");
        value = $random(seed);
        if (value == '0) begin
            value = 32'h1;
        end
        busWrite(`LFSR_ADDRESS, value, 4'hF);
        readExpect(`LFSR_ADDRESS, value, "lfsr seed");
        repeat (5) busRead(`LFSR_ADDRESS, junk);
        busWrite(`LFSR_ADDRESS, 32'h0, 4'hF);
        repeat (2) busRead(`LFSR_ADDRESS, junk);

        // manual mode, one tick per step press
        repeat (2) begin
            pressKey(`KEY_STEP);
            waitTick(20);
        end

        // auto mode at two divider settings
        @(posedge iCLK);
        SW[4:0] <= 5'd2 + 5'(32'($random(seed)) & 7);
        pressKey(`KEY_MODE);
        repeat (8) waitTick(64);
        @(posedge iCLK);
        SW[4:0] <= 5'd2 + 5'(32'($random(seed)) & 7);
        repeat (8) waitTick(64);

        // ebreak halts, steps still pass, resume by write
        @(posedge iCLK);
        ebreak <= 1'b1;
        waitTick(64);
        @(posedge iCLK);
        ebreak <= 1'b0;
        waitHalt(1'b1, 4);
        repeat (2) begin
            pressKey(`KEY_STEP);
            waitTick(20);
        end
        repeat (40) @(posedge iCLK);
        busWrite(`BREAK_CTRL_ADDRESS, 32'h2, 4'hF);
        waitHalt(1'b0, 4);

        // breakpoint written half by half with junk in the masked lanes
        bp   = 32'($random(seed)) & 32'hFFFF_FFFC;
        junk = $random(seed);
        busWrite(`BREAK_ADDR_ADDRESS, (bp & 32'h0000_FFFF) | (junk & 32'hFFFF_0000), 4'b0011);
        busWrite(`BREAK_ADDR_ADDRESS, (bp & 32'hFFFF_0000) | (junk & 32'h0000_FFFF), 4'b1100);
        readExpect(`BREAK_ADDR_ADDRESS, bp, "breakpoint address");
        busWrite(`BREAK_CTRL_ADDRESS, 32'h1, 4'hF);
        @(posedge iCLK);
        pc <= bp;
        waitHalt(1'b1, 64);
        busRead(`BREAK_CTRL_ADDRESS, junk);
        @(posedge iCLK);
        pc <= bp + 32'd4;
        busWrite(`BREAK_CTRL_ADDRESS, 32'h3, 4'hF);
        waitHalt(1'b0, 4);
        waitTick(64);
        @(posedge iCLK);
        pc <= bp;
        waitHalt(1'b1, 64);
        @(posedge iCLK);
        pc <= bp ^ 32'h10;
        pressKey(`KEY_RESUME);
        waitHalt(1'b0, 20);
        busWrite(`BREAK_CTRL_ADDRESS, 32'h0, 4'hF);
        busRead(`BREAK_CTRL_ADDRESS, junk);

        repeat (5) @(posedge iCLK);
        fails = boardTop_inst.boardAssert_inst.assertFails;
        $display("checks done: %0d testbench errors, %0d assertion failures", tbErrors, fails);
        if (tbErrors == 0 && fails == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: bench/board_assert.sv
// board checker
// concurrent assertions with small reference models, bound into the board top
`timescale 1ns/1ns
`include "board_consts.svh"

module boardAssert (
    input logic           iCLK,
    input logic           rstN,
    input logic [9:0]     SW,
    input logic [3:0]     KEY,
    input boardPkg::wordT pc,
    input boardPkg::wordT instr,
    input logic           ebreak,
    input logic           readEnable,
    input logic           writeEnable,
    input boardPkg::wordT address,
    input boardPkg::wordT writeData,
    input logic [3:0]     byteEnable,
    input boardPkg::wordT readData,
    input logic           cpuTick,
    input boardPkg::segT  HEX0,
    input boardPkg::segT  HEX1,
    input boardPkg::segT  HEX2,
    input boardPkg::segT  HEX3,
    input boardPkg::segT  HEX4,
    input boardPkg::segT  HEX5,
    input logic [9:0]     LEDR
);
    import boardPkg::*;

    // failures so far, the testbench reads this at the end
    int assertFails = 0;

    wordT        sinceClear;
    wordT        lfsrModel;
    wordT        bpAddrModel;
    wordT        gapCount;
    wordT        autoQuiet;
    wordT        shownWord;
    logic        bpEnModel;
    logic        modeModel;
    logic        mapped;
    logic        hitNow;
    logic        hitLast;
    logic        resumeWrite;
    logic        stepPressed;
    logic        stepUsed;
    logic [3:0]  keyLast;
    logic [2:0]  resumeAge;
    logic [1:0]  modeAge;
    logic [7:0]  stepCredit;
    logic [4:0]  fdivLast;
    logic [41:0] hexAll;

    // one right-shift step of the Galois register
    function automatic wordT lfsrNext(input wordT value);
        wordT fold;
        fold = value[0] ? `LFSR_TAPS : 32'h0;
        return {1'b0, value[31:1]} ^ fold;
    endfunction

    assign mapped = (address == `DIVIDER_ADDRESS) || (address == `STOPWATCH_ADDRESS)
        || (address == `LFSR_ADDRESS) || (address == `BREAK_ADDR_ADDRESS)
        || (address == `BREAK_CTRL_ADDRESS);
    // LEDR[1] is halted, LEDR[2] is auto mode
    assign hitNow = cpuTick && (ebreak || (bpEnModel && pc == bpAddrModel));
    assign resumeWrite = writeEnable && (address == `BREAK_CTRL_ADDRESS) && writeData[1];
    assign stepPressed = keyLast[`KEY_STEP] && !KEY[`KEY_STEP];
    assign stepUsed = cpuTick && (LEDR[1] || !LEDR[2]);
    assign shownWord = SW[8] ? instr : pc;
    assign hexAll = {HEX5, HEX4, HEX3, HEX2, HEX1, HEX0};

    // bus-side models
    always_ff @(posedge iCLK or negedge rstN) begin
        if (!rstN) begin
            sinceClear  <= '0;
            lfsrModel   <= `LFSR_SEED;
            bpAddrModel <= '0;
            bpEnModel   <= 1'b0;
        end else begin
            // strobe cycle counts as cycle 0, so the next one is 1
            if (writeEnable && address == `STOPWATCH_ADDRESS) begin
                sinceClear <= 32'd1;
            end else begin
                sinceClear <= sinceClear + 32'd1;
            end
            if (writeEnable && address == `LFSR_ADDRESS) begin
                if (writeData != '0) begin
                    lfsrModel <= writeData;
                end
            end else if (readEnable && address == `LFSR_ADDRESS) begin
                lfsrModel <= lfsrNext(lfsrModel);
            end
            if (writeEnable && address == `BREAK_ADDR_ADDRESS) begin
                for (int lane = 0; lane < 4; lane++) begin
                    if (byteEnable[lane]) begin
                        bpAddrModel[lane*8 +: 8] <= writeData[lane*8 +: 8];
                    end
                end
            end
            if (writeEnable && address == `BREAK_CTRL_ADDRESS) begin
                bpEnModel <= writeData[0];
            end
        end
    end

    // stepping models: key edges, mode lamp, step credit, tick spacing
    always_ff @(posedge iCLK or negedge rstN) begin
        if (!rstN) begin
            keyLast    <= 4'hF;
            resumeAge  <= '0;
            modeAge    <= '0;
            modeModel  <= 1'b0;
            hitLast    <= 1'b0;
            stepCredit <= '0;
            fdivLast   <= '0;
            gapCount   <= '0;
            autoQuiet  <= '0;
        end else begin
            keyLast   <= KEY;
            resumeAge <= {resumeAge[1:0], keyLast[`KEY_RESUME] && !KEY[`KEY_RESUME]};
            // two sync flops plus edge detect before the mode flips
            modeAge   <= {modeAge[0], keyLast[`KEY_MODE] && !KEY[`KEY_MODE]};
            if (modeAge[1]) begin
                modeModel <= !modeModel;
            end
            hitLast   <= hitNow;
            fdivLast  <= SW[4:0];
            if (stepPressed && !stepUsed) begin
                stepCredit <= stepCredit + 8'd1;
            end else if (stepUsed && !stepPressed && stepCredit != 8'd0) begin
                stepCredit <= stepCredit - 8'd1;
            end
            gapCount <= cpuTick ? 32'd1 : gapCount + 32'd1;
            // unbroken auto run with no keys and steady switches
            if (LEDR[2] && !LEDR[1] && KEY == 4'hF && SW[4:0] == fdivLast) begin
                autoQuiet <= autoQuiet + 32'd1;
            end else begin
                autoQuiet <= '0;
            end
        end
    end

    resetState: assert property (@(posedge iCLK) !rstN |-> (LEDR == 10'd0 && !cpuTick))
        else begin
            $error("outputs not cleared in reset");
            assertFails++;
        end
    idleRead: assert property (@(posedge iCLK) disable iff (!rstN)
        !readEnable |-> readData == '0)
        else begin
            $error("read data not zero without a read");
            assertFails++;
        end
    unmappedRead: assert property (@(posedge iCLK) disable iff (!rstN)
        readEnable && !mapped |-> readData == '0)
        else begin
            $error("unmapped address answered");
            assertFails++;
        end
    dividerRead: assert property (@(posedge iCLK) disable iff (!rstN)
        readEnable && address == `DIVIDER_ADDRESS |-> readData == {27'b0, SW[4:0]})
        else begin
            $error("divider readback wrong");
            assertFails++;
        end
    stopwatchRead: assert property (@(posedge iCLK) disable iff (!rstN)
        readEnable && address == `STOPWATCH_ADDRESS
        |-> readData == sinceClear / `STOPWATCH_PRESCALE)
        else begin
            $error("stopwatch count wrong");
            assertFails++;
        end
    lfsrRead: assert property (@(posedge iCLK) disable iff (!rstN)
        readEnable && address == `LFSR_ADDRESS |-> readData == lfsrModel)
        else begin
            $error("lfsr value wrong");
            assertFails++;
        end
    bpAddrRead: assert property (@(posedge iCLK) disable iff (!rstN)
        readEnable && address == `BREAK_ADDR_ADDRESS |-> readData == bpAddrModel)
        else begin
            $error("breakpoint address readback wrong");
            assertFails++;
        end
    bpCtrlRead: assert property (@(posedge iCLK) disable iff (!rstN)
        readEnable && address == `BREAK_CTRL_ADDRESS
        |-> readData == {30'b0, LEDR[1], bpEnModel})
        else begin
            $error("breakpoint control readback wrong");
            assertFails++;
        end
    haltOnHit: assert property (@(posedge iCLK) disable iff (!rstN) hitNow |=> LEDR[1])
        else begin
            $error("halt missing after breakpoint or ebreak");
            assertFails++;
        end
    noStrayHalt: assert property (@(posedge iCLK) disable iff (!rstN)
        !LEDR[1] && !hitNow |=> !LEDR[1])
        else begin
            $error("halt rose without a hit");
            assertFails++;
        end
    resumeByWrite: assert property (@(posedge iCLK) disable iff (!rstN)
        resumeWrite && !hitNow |=> !LEDR[1])
        else begin
            $error("resume write did not clear halt");
            assertFails++;
        end
    resumeByKey: assert property (@(posedge iCLK) disable iff (!rstN)
        resumeAge[2] && !hitLast |-> !LEDR[1])
        else begin
            $error("resume key did not clear halt");
            assertFails++;
        end
    stepOnly: assert property (@(posedge iCLK) disable iff (!rstN)
        stepUsed |-> stepCredit != 8'd0)
        else begin
            $error("tick without a step press");
            assertFails++;
        end
    autoSpacing: assert property (@(posedge iCLK) disable iff (!rstN)
        cpuTick && autoQuiet > gapCount + 32'd8 |-> gapCount == {27'b0, SW[4:0]} + 32'd1)
        else begin
            $error("auto tick spacing wrong");
            assertFails++;
        end
    modeLamp: assert property (@(posedge iCLK) disable iff (!rstN) LEDR[2] == modeModel)
        else begin
            $error("auto mode lamp wrong");
            assertFails++;
        end
    ledMap: assert property (@(posedge iCLK) disable iff (!rstN)
        LEDR[9:3] == '0 && LEDR[0] == cpuTick)
        else begin
            $error("LED mapping wrong");
            assertFails++;
        end

    // one check per display digit
    for (genvar d = 0; d < 6; d++) begin : digitCheck
        digitShown: assert property (@(posedge iCLK) disable iff (!rstN)
            hexAll[d*7 +: 7] == hexSegTable[shownWord[d*4 +: 4]])
            else begin
                $error("display digit %0d wrong", d);
                assertFails++;
            end
    end

endmodule

bind boardTop boardAssert boardAssert_inst (.*);

// File: verilog/boardTop.sv
// board top level
// hangs the board peripherals on the data bus and drives LEDs and displays
`timescale 1ns/1ns

module boardTop (
    input  logic           iCLK,
    input  logic           rstN,
    input  logic [9:0]     SW,
    input  logic [3:0]     KEY,
    input  boardPkg::wordT pc,
    input  boardPkg::wordT instr,
    input  logic           ebreak,
    input  logic           readEnable,
    input  logic           writeEnable,
    input  boardPkg::wordT address,
    input  boardPkg::wordT writeData,
    input  logic [3:0]     byteEnable,
    output boardPkg::wordT readData,
    output logic           cpuTick,
    output boardPkg::segT  HEX0,
    output boardPkg::segT  HEX1,
    output boardPkg::segT  HEX2,
    output boardPkg::segT  HEX3,
    output boardPkg::segT  HEX4,
    output boardPkg::segT  HEX5,
    output logic [9:0]     LEDR
);
    import boardPkg::*;

    // device readback words
    wordT   dividerWord;
    wordT   stopwatchWord;
    wordT   lfsrWord;
    wordT   breakAddrWord;
    wordT   breakCtrlWord;
    // decoded strobes
    logic   swWrite;
    logic   lfsrWrite;
    logic   lfsrRead;
    logic   breakAddrWrite;
    logic   breakCtrlWrite;
    // stepping state
    logic   halted;
    logic   autoMode;

    // divider switches read back zero-extended
    assign dividerWord = {27'b0, SW[4:0]};

    busDecoder busDecoder_inst (
        .address       (address),
        .readEnable    (readEnable),
        .writeEnable   (writeEnable),
        .dividerWord   (dividerWord),
        .stopwatchWord (stopwatchWord),
        .lfsrWord      (lfsrWord),
        .breakAddrWord (breakAddrWord),
        .breakCtrlWord (breakCtrlWord),
        .readData      (readData),
        .devSel        (),
        .swWrite       (swWrite),
        .lfsrWrite     (lfsrWrite),
        .breakAddrWrite(breakAddrWrite),
        .breakCtrlWrite(breakCtrlWrite),
        .lfsrRead      (lfsrRead)
    );

    clockStepper clockStepper_inst (
        .iCLK    (iCLK),
        .rstN    (rstN),
        .fdiv    (SW[4:0]),
        .key     (KEY),
        .halted  (halted),
        .cpuTick (cpuTick),
        .autoMode(autoMode)
    );

    stopwatch stopwatch_inst (
        .iCLK (iCLK),
        .rstN (rstN),
        .clear(swWrite),
        .count(stopwatchWord)
    );

    // write data doubles as the seed
    lfsrRandom lfsrRandom_inst (
        .iCLK (iCLK),
        .rstN (rstN),
        .load (lfsrWrite),
        .step (lfsrRead),
        .seed (writeData),
        .state(lfsrWord)
    );

    breakUnit breakUnit_inst (
        .iCLK      (iCLK),
        .rstN      (rstN),
        .cpuTick   (cpuTick),
        .pc        (pc),
        .ebreak    (ebreak),
        .key       (KEY),
        .addrWrite (breakAddrWrite),
        .ctrlWrite (breakCtrlWrite),
        .writeData (writeData),
        .byteEnable(byteEnable),
        .breakAddr (breakAddrWord),
        .breakCtrl (breakCtrlWord),
        .halted    (halted)
    );

    hexDisplay hexDisplay_inst (
        .pc    (pc),
        .instr (instr),
        .select(SW[9:8]),
        .hex0  (HEX0),
        .hex1  (HEX1),
        .hex2  (HEX2),
        .hex3  (HEX3),
        .hex4  (HEX4),
        .hex5  (HEX5)
    );

    // tick, halt and mode lamps, the rest stay dark
    assign LEDR = {7'b0, autoMode, halted, cpuTick};

endmodule

// File: verilog/hexDisplay.sv
// seven-segment display driver
// shows the low six nibbles of the cpu pc or instruction word
`timescale 1ns/1ns

module hexDisplay (
    input  boardPkg::wordT pc,
    input  boardPkg::wordT instr,
    input  logic [1:0]     select,
    output boardPkg::segT  hex0,
    output boardPkg::segT  hex1,
    output boardPkg::segT  hex2,
    output boardPkg::segT  hex3,
    output boardPkg::segT  hex4,
    output boardPkg::segT  hex5
);
    import boardPkg::*;

    wordT shownWord;

    // switch codes as on the board, upper bit is a spare slot
    always_comb begin
        case (select)
            2'b11:   shownWord = instr;
            2'b10:   shownWord = pc;
            2'b01:   shownWord = instr;
            default: shownWord = pc;
        endcase
    end

    // digit 0 is the rightmost, least significant nibble
    always_comb begin
        hex0 = hexSegTable[shownWord[3:0]];
        hex1 = hexSegTable[shownWord[7:4]];
        hex2 = hexSegTable[shownWord[11:8]];
        hex3 = hexSegTable[shownWord[15:12]];
        hex4 = hexSegTable[shownWord[19:16]];
        hex5 = hexSegTable[shownWord[23:20]];
    end

    // top two nibbles have no digit on this board

endmodule

// File: verilog/breakUnit.sv
// breakpoint unit
// halts stepping on a pc match or an ebreak, resumed by bus write or key
`timescale 1ns/1ns
`include "board_consts.svh"

module breakUnit (
    input  logic           iCLK,
    input  logic           rstN,
    input  logic           cpuTick,
    input  boardPkg::wordT pc,
    input  logic           ebreak,
    input  logic [3:0]     key,
    input  logic           addrWrite,
    input  logic           ctrlWrite,
    input  boardPkg::wordT writeData,
    input  logic [3:0]     byteEnable,
    output boardPkg::wordT breakAddr,
    output boardPkg::wordT breakCtrl,
    output logic           halted
);
    import boardPkg::*;

    logic [1:0] resumeSync;
    logic       resumePrev;
    logic       resumePress;
    logic       breakEnable;
    logic       breakHit;
    logic       resumeReq;

    // resume key sync and falling-edge detect
    always_ff @(posedge iCLK or negedge rstN) begin
        if (!rstN) begin
            resumeSync <= 2'b11;
            resumePrev <= 1'b1;
        end else begin
            resumeSync <= {resumeSync[0], key[`KEY_RESUME]};
            resumePrev <= resumeSync[1];
        end
    end

    assign resumePress = resumePrev && !resumeSync[1];

    // address register honours byte lanes
    always_ff @(posedge iCLK or negedge rstN) begin
        if (!rstN) begin
            breakAddr <= '0;
        end else if (addrWrite) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (byteEnable[lane]) begin
                    breakAddr[lane*8 +: 8] <= writeData[lane*8 +: 8];
                end
            end
        end
    end

    // control takes the whole word, only bit 0 is stored
    always_ff @(posedge iCLK or negedge rstN) begin
        if (!rstN) begin
            breakEnable <= 1'b0;
        end else if (ctrlWrite) begin
            breakEnable <= writeData[0];
        end
    end

    // only ticks are checked, the pc is stale in between
    assign breakHit  = cpuTick && (ebreak || (breakEnable && (pc == breakAddr)));
    // resume bit is a pulse, it never stays set
    assign resumeReq = (ctrlWrite && writeData[1]) || resumePress;

    always_ff @(posedge iCLK or negedge rstN) begin
        if (!rstN) begin
            halted <= 1'b0;
        end else if (breakHit) begin
            halted <= 1'b1;
        end else if (resumeReq) begin
            halted <= 1'b0;
        end
    end

    // bit 1 reads back the halt state
    assign breakCtrl = {30'b0, halted, breakEnable};

endmodule

// File: verilog/lfsrRandom.sv
// pseudo-random word generator
// 32-bit Galois LFSR, loaded by a bus write and stepped on every read
`timescale 1ns/1ns
`include "board_consts.svh"

module lfsrRandom (
    input  logic           iCLK,
    input  logic           rstN,
    input  logic           load,
    input  logic           step,
    input  boardPkg::wordT seed,
    output boardPkg::wordT state
);
    import boardPkg::*;

    wordT nextState;

    // shift right, fold the taps in when a one falls out
    assign nextState = state[0] ? ((state >> 1) ^ `LFSR_TAPS) : (state >> 1);

    always_ff @(posedge iCLK or negedge rstN) begin
        if (!rstN) begin
            state <= `LFSR_SEED;
        end else if (load) begin
            // zero would lock the register up
            if (seed != '0) begin
                state <= seed;
            end
        end else if (step) begin
            state <= nextState;
        end
    end

endmodule

// File: verilog/stopwatch.sv
// stopwatch
// elapsed count in units of a fixed prescale, cleared by a bus write
`timescale 1ns/1ns
`include "board_consts.svh"

module stopwatch (
    input  logic           iCLK,
    input  logic           rstN,
    input  logic           clear,
    output boardPkg::wordT count
);
    import boardPkg::*;

    localparam int PreWidth = $clog2(`STOPWATCH_PRESCALE);
    localparam logic [PreWidth-1:0] PreLast = PreWidth'(`STOPWATCH_PRESCALE - 1);

    logic [PreWidth-1:0] prescaleCount;

    // the clear cycle already counts as the first prescale cycle,
    // so the count reaches 1 exactly prescale cycles after the write
    always_ff @(posedge iCLK or negedge rstN) begin
        if (!rstN) begin
            prescaleCount <= '0;
            count         <= '0;
        end else if (clear) begin
            prescaleCount <= PreWidth'(1);
            count         <= '0;
        end else if (prescaleCount == PreLast) begin
            prescaleCount <= '0;
            count         <= count + 32'd1;
        end else begin
            prescaleCount <= prescaleCount + PreWidth'(1);
        end
    end

endmodule

// File: verilog/clockStepper.sv
// clock stepper
// turns the board clock into cpu step ticks in auto, manual and halt modes
`timescale 1ns/1ns
`include "board_consts.svh"

module clockStepper (
    input  logic       iCLK,
    input  logic       rstN,
    input  logic [4:0] fdiv,
    input  logic [3:0] key,
    input  logic       halted,
    output logic       cpuTick,
    output logic       autoMode
);
    logic [3:0] keySync1;
    logic [3:0] keySync2;
    logic [3:0] keyPrev;
    logic [3:0] keyPress;
    logic [4:0] divCount;
    logic       stepPending;
    logic       autoFire;
    logic       stepFire;

    // two-flop sync, then one more stage for edge detect
    always_ff @(posedge iCLK or negedge rstN) begin
        if (!rstN) begin
            keySync1 <= 4'hF;
            keySync2 <= 4'hF;
            keyPrev  <= 4'hF;
        end else begin
            keySync1 <= key;
            keySync2 <= keySync1;
            keyPrev  <= keySync2;
        end
    end

    // keys are active low, a press is a falling edge
    assign keyPress = keyPrev & ~keySync2;

    // down counter, period is fdiv+1 cycles
    always_ff @(posedge iCLK or negedge rstN) begin
        if (!rstN) begin
            divCount <= '0;
        end else if (divCount == 5'd0) begin
            divCount <= fdiv;
        end else begin
            divCount <= divCount - 5'd1;
        end
    end

    assign autoFire = autoMode && !halted && (divCount == 5'd0);
    // a step waits out a colliding auto tick so it is never swallowed
    assign stepFire = stepPending && !autoFire;
    assign cpuTick  = autoFire || stepFire;

    always_ff @(posedge iCLK or negedge rstN) begin
        if (!rstN) begin
            autoMode    <= 1'b0;
            stepPending <= 1'b0;
        end else begin
            if (keyPress[`KEY_MODE]) begin
                autoMode <= !autoMode;
            end
            // new press wins over the pulse just issued
            if (keyPress[`KEY_STEP]) begin
                stepPending <= 1'b1;
            end else if (stepFire) begin
                stepPending <= 1'b0;
            end
        end
    end

endmodule

// File: verilog/busDecoder.sv
// bus decoder
// picks the addressed device, qualifies the strobes and returns read data
`timescale 1ns/1ns
`include "board_consts.svh"

module busDecoder (
    input  boardPkg::wordT   address,
    input  logic             readEnable,
    input  logic             writeEnable,
    input  boardPkg::wordT   dividerWord,
    input  boardPkg::wordT   stopwatchWord,
    input  boardPkg::wordT   lfsrWord,
    input  boardPkg::wordT   breakAddrWord,
    input  boardPkg::wordT   breakCtrlWord,
    output boardPkg::wordT   readData,
    output boardPkg::devSelT devSel,
    output logic             swWrite,
    output logic             lfsrWrite,
    output logic             breakAddrWrite,
    output logic             breakCtrlWrite,
    output logic             lfsrRead
);
    import boardPkg::*;

    // full-word compare, anything else is unmapped
    always_comb begin
        devSel = devNone;
        if (address == `DIVIDER_ADDRESS) begin
            devSel = devDivider;
        end else if (address == `STOPWATCH_ADDRESS) begin
            devSel = devStopwatch;
        end else if (address == `LFSR_ADDRESS) begin
            devSel = devLfsr;
        end else if (address == `BREAK_ADDR_ADDRESS) begin
            devSel = devBreakAddr;
        end else if (address == `BREAK_CTRL_ADDRESS) begin
            devSel = devBreakCtrl;
        end
    end

    // divider readback is read-only, so no write strobe for it
    assign swWrite        = writeEnable && (devSel == devStopwatch);
    assign lfsrWrite      = writeEnable && (devSel == devLfsr);
    assign breakAddrWrite = writeEnable && (devSel == devBreakAddr);
    assign breakCtrlWrite = writeEnable && (devSel == devBreakCtrl);
    // reading the lfsr advances it
    assign lfsrRead       = readEnable && (devSel == devLfsr);

    // zero when idle or nobody answers
    always_comb begin
        readData = '0;
        if (readEnable) begin
            case (devSel)
                devDivider:   readData = dividerWord;
                devStopwatch: readData = stopwatchWord;
                devLfsr:      readData = lfsrWord;
                devBreakAddr: readData = breakAddrWord;
                devBreakCtrl: readData = breakCtrlWord;
                default:      readData = '0;
            endcase
        end
    end

endmodule

// File: verilog/boardPkg.sv
// board package
// bus word, device-select and seven-segment types plus the hex digit table
package boardPkg;

    // one bus or register word
    typedef logic [31:0] wordT;

    // device answering the current address
    typedef enum logic [2:0] {
        devNone,
        devDivider,
        devStopwatch,
        devLfsr,
        devBreakAddr,
        devBreakCtrl
    } devSelT;

    // active-low segments, bit 6 is g and bit 0 is a
    typedef logic [6:0] segT;

    // digit pattern per nibble value
    localparam segT hexSegTable [0:15] = '{
        7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
        7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
        7'b0000000, 7'b0010000, 7'b0001000, 7'b0000011,
        7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110
    };

endpackage

// File: verilog/board_consts.svh
// board constants
// register addresses, stopwatch prescale, LFSR polynomial and key indices
`ifndef BOARD_CONSTS_SVH
`define BOARD_CONSTS_SVH

// memory-mapped register addresses, one word each
`define DIVIDER_ADDRESS     32'hFF20_0100
`define STOPWATCH_ADDRESS   32'hFF20_0510
`define LFSR_ADDRESS        32'hFF20_0514
`define BREAK_ADDR_ADDRESS  32'hFF20_0600
`define BREAK_CTRL_ADDRESS  32'hFF20_0604

// clock cycles per stopwatch count
`define STOPWATCH_PRESCALE  8

// right-shift Galois mask for x^32 + x^22 + x^2 + x + 1
`define LFSR_TAPS           32'h8020_0003
// state after reset, must be nonzero
`define LFSR_SEED           32'hACE1_2345

// positions in the active-low KEY input
`define KEY_MODE            1
`define KEY_STEP            2
`define KEY_RESUME          3

`endif
